/* build.f */
+incdir+.
axi_lite_pkg.sv
xbar_map_pkg.sv
slv_rd_if.sv
rd_addr_decoder.sv
rd_slave_arbiter.sv
rd_master_return.sv
axi_lite_rd_xbar.sv
rd_xbar_checker.sv
tb_rd_xbar.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rd_xbar -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rd_xbar 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* tb_rd_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module tb_rd_xbar;

    localparam int TIMEOUT_CYCLES = 6000;

    logic        aclk;
    logic        aresetn;
    logic [63:0] araddr;
    logic [5:0]  arprot;
    logic [1:0]  arvalid;
    logic [1:0]  rready;
    logic [3:0]  s_rresp;
    wire  [1:0]  arready_o;
    wire  [63:0] rdata_o;
    wire  [3:0]  rresp_o;
    wire  [1:0]  rvalid_o;
    wire  [63:0] s_araddr_o;
    wire  [5:0]  s_arprot_o;
    wire  [1:0]  s_arvalid_o;
    wire  [1:0]  s_arready;
    wire  [63:0] s_rdata;
    wire  [1:0]  s_rvalid;
    wire  [1:0]  s_rready_o;
    int          cycles;

    axi_lite_rd_xbar uut (
        .aclk(aclk), .aresetn(aresetn),
        .araddr_i(araddr), .arprot_i(arprot), .arvalid_i(arvalid),
        .arready_o(arready_o), .rdata_o(rdata_o), .rresp_o(rresp_o),
        .rvalid_o(rvalid_o), .rready_i(rready),
        .s_araddr_o(s_araddr_o), .s_arprot_o(s_arprot_o), .s_arvalid_o(s_arvalid_o),
        .s_arready_i(s_arready), .s_rdata_i(s_rdata), .s_rresp_i(s_rresp),
        .s_rvalid_i(s_rvalid), .s_rready_o(s_rready_o)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Error: timeout, the reads did not complete in time");
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // ----------------------------------------------------------------------
    // Slave models returning the address XOR (index + 1) in the top byte
    // ----------------------------------------------------------------------
    for (genvar g = 0; g < 2; g++) begin : g_slave
        logic        arready_q;
        logic        rvalid_q;
        logic [31:0] rdata_q;
        logic [31:0] addr_q;

        assign s_arready[g]         = arready_q;
        assign s_rvalid[g]          = rvalid_q;
        assign s_rdata[g*32 +: 32]  = rdata_q;

        initial begin
            arready_q = 1'b0;
            rvalid_q  = 1'b0;
            rdata_q   = '0;
            addr_q    = '0;
            wait (aresetn);
            forever begin
                @(negedge aclk);
                #5;
                if (s_arvalid_o[g]) begin
                    addr_q = s_araddr_o[g*32 +: 32];
                    repeat ($urandom_range(0, 3)) @(negedge aclk);
                    @(negedge aclk);
                    arready_q = 1'b1;
                    @(negedge aclk);
                    arready_q = 1'b0;
                    repeat ($urandom_range(0, 3)) @(negedge aclk);
                    rvalid_q = 1'b1;
                    rdata_q  = addr_q ^ (32'(g + 1) << 24);
                    #5;
                    while (!s_rready_o[g]) begin
                        @(negedge aclk);
                        #5;
                    end
                    @(negedge aclk);
                    rvalid_q = 1'b0;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // Expected R beat from the region map and security rule
    task automatic predict_read(input logic [31:0] addr, input logic [2:0] prot,
                                output logic [31:0] data, output logic [1:0] resp);
        if ((addr & `XBAR_REG1_MASK) == `XBAR_REG1_BASE) begin
            data = addr ^ 32'h0200_0000;
            resp = 2'b00;
        end else if ((addr & `XBAR_REG0_MASK) == `XBAR_REG0_BASE && !prot[1]) begin
            data = addr ^ 32'h0100_0000;
            resp = 2'b00;
        end else begin
            data = `XBAR_ERR_DATA;
            resp = 2'b11;
        end
    endtask

    // One read on master m
    // Stall holds RREADY low for that many valid cycles
    task automatic run_read(input int m, input logic [31:0] addr, input logic [2:0] prot,
                            input string name, input bit bp, input int stall);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        int          hold;
        int          slv;
        bit          done;
        predict_read(addr, prot, exp_data, exp_resp);
        hold = stall;
        done = 1'b0;
        @(negedge aclk);
        araddr[m*32 +: 32] = addr;
        arprot[m*3 +: 3]   = prot;
        arvalid[m]         = 1'b1;
        #5;
        while (!arready_o[m]) begin
            @(negedge aclk);
            #5;
        end
        // Forwarded AR seen by the slave that the region map selects
        if (exp_resp == 2'b00) begin
            slv = ((addr & `XBAR_REG1_MASK) == `XBAR_REG1_BASE) ? 1 : 0;
            check_value({name, " s_araddr"}, addr, s_araddr_o[slv*32 +: 32]);
            check_value({name, " s_arprot"}, 32'(prot), 32'(s_arprot_o[slv*3 +: 3]));
        end
        @(negedge aclk);
        arvalid[m] = 1'b0;
        while (!done) begin
            if (hold > 0) rready[m] = 1'b0;
            else if (bp) rready[m] = 1'($urandom_range(0, 1));
            else rready[m] = 1'b1;
            #5;
            if (rvalid_o[m] && hold > 0) begin
                hold--;
            end else if (rvalid_o[m] && rready[m]) begin
                check_value({name, " rdata"}, exp_data, rdata_o[m*32 +: 32]);
                check_value({name, " rresp"}, 32'(exp_resp), 32'(rresp_o[m*2 +: 2]));
                done = 1'b1;
            end
            @(negedge aclk);
        end
        rready[m] = 1'b0;
    endtask

    task automatic contend(input int m, input int count);
        for (int i = 0; i < count; i++) begin
            run_read(m, {16'h1000, 16'($urandom)}, 3'(m * 2), "contention", 1'b0, 0);
        end
    endtask

    initial begin
        void'($urandom(32'h8b421fd5));
        cycles  = 0;
        aresetn = 1'b0;
        araddr  = '0;
        arprot  = '0;
        arvalid = '0;
        // Masters ready for R through reset to expose a stray grant
        rready  = '1;
        s_rresp = '0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        #5;
        check_value("reset arready", 32'd0, 32'(arready_o));
        check_value("reset rvalid", 32'd0, 32'(rvalid_o));
        check_value("reset s_arvalid", 32'd0, 32'(s_arvalid_o));
        check_value("reset s_rready", 32'd0, 32'(s_rready_o));
        rready = '0;

        // Region 1 open to both masters and both security levels
        run_read(0, 32'h1000_0010, 3'b000, "region1 secure m0", 1'b0, 0);
        run_read(0, 32'h1000_0020, 3'b010, "region1 nonsec m0", 1'b0, 0);
        run_read(1, 32'h1000_0030, 3'b000, "region1 secure m1", 1'b0, 0);
        run_read(1, 32'h1000_0040, 3'b010, "region1 nonsec m1", 1'b0, 0);

        // Region 0 secure-only
        run_read(0, 32'h0000_0100, 3'b000, "region0 secure", 1'b0, 0);
        run_read(1, 32'h0000_0200, 3'b010, "region0 nonsec", 1'b0, 0);

        // Unmapped with a stalled error beat and a good read after it
        run_read(0, 32'h2000_0000, 3'b000, "unmapped", 1'b0, 3);
        run_read(0, 32'h1000_0050, 3'b000, "after error", 1'b0, 0);

        fork
            contend(0, 30);
            contend(1, 30);
        join

        for (int i = 0; i < 40; i++) begin
            run_read(i % 2, {16'h1000 - 16'(i % 4 / 2 * 16'h1000), 16'($urandom)},
                     3'b000, "backpressure", 1'b1, 0);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* rd_xbar_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module rd_xbar_checker (
    input wire logic                                aclk,
    input wire logic                                aresetn,
    input wire logic [`XBAR_N_MST*`XBAR_ADDR_W-1:0] araddr_i,
    input wire logic [`XBAR_N_MST*3-1:0]            arprot_i,
    input wire logic [`XBAR_N_MST-1:0]              arvalid_i,
    input wire logic [`XBAR_N_MST*`XBAR_DATA_W-1:0] rdata_o,
    input wire logic [`XBAR_N_MST-1:0]              rvalid_o,
    input wire logic [`XBAR_N_MST-1:0]              rready_i,
    input wire logic [`XBAR_N_SLV*`XBAR_ADDR_W-1:0] s_araddr_o,
    input wire logic [`XBAR_N_SLV-1:0]              s_arvalid_o,
    input wire logic [`XBAR_N_SLV-1:0]              s_arready_i,
    input wire logic [`XBAR_N_SLV-1:0]              s_rvalid_i,
    input wire logic [`XBAR_N_SLV-1:0]              s_rready_o
);

    logic [`XBAR_N_SLV-1:0] outstanding;
    logic [`XBAR_N_MST-1:0] refused;

    // Slave busy from its AR handshake to its R handshake
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            outstanding <= '0;
        end else begin
            for (int s = 0; s < `XBAR_N_SLV; s++) begin
                if (s_arvalid_o[s] && s_arready_i[s]) begin
                    outstanding[s] <= 1'b1;
                end else if (s_rvalid_i[s] && s_rready_o[s]) begin
                    outstanding[s] <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Per-master properties
    // ----------------------------------------------------------------------
    for (genvar m = 0; m < `XBAR_N_MST; m++) begin : g_mst
        logic [`XBAR_ADDR_W-1:0] addr;
        logic                    in0;
        logic                    in1;

        assign addr = araddr_i[m*`XBAR_ADDR_W +: `XBAR_ADDR_W];
        assign in0  = (addr & `XBAR_REG0_MASK) == `XBAR_REG0_BASE;
        assign in1  = (addr & `XBAR_REG1_MASK) == `XBAR_REG1_BASE;
        // Unmapped, or non-secure into the secure-only region
        assign refused[m] = arvalid_i[m] && !(in1 || (in0 && !arprot_i[m*3+1]));

        r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
            rvalid_o[m] && !rready_i[m] |=>
                rvalid_o[m] && $stable(rdata_o[m*`XBAR_DATA_W +: `XBAR_DATA_W]))
            else $error("R channel changed while RREADY was low");

        for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_slv
            refuse_blocked: assert property (@(posedge aclk) disable iff (!aresetn)
                refused[m] |->
                    !(s_arvalid_o[s] && s_araddr_o[s*`XBAR_ADDR_W +: `XBAR_ADDR_W] == addr))
                else $error("Refused read reached a slave");
        end
    end

    // ----------------------------------------------------------------------
    // Per-slave properties
    // ----------------------------------------------------------------------
    for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_slv
        ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
            s_arvalid_o[s] && !s_arready_i[s] |=> s_arvalid_o[s])
            else $error("Forwarded ARVALID dropped before ARREADY");

        single_outstanding: assert property (@(posedge aclk) disable iff (!aresetn)
            outstanding[s] |-> !s_arvalid_o[s])
            else $error("Second AR forwarded before the R handshake");
    end

endmodule

bind axi_lite_rd_xbar rd_xbar_checker u_chk (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .araddr_i    (araddr_i),
    .arprot_i    (arprot_i),
    .arvalid_i   (arvalid_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .s_araddr_o  (s_araddr_o),
    .s_arvalid_o (s_arvalid_o),
    .s_arready_i (s_arready_i),
    .s_rvalid_i  (s_rvalid_i),
    .s_rready_o  (s_rready_o)
);

`default_nettype wire

/* axi_lite_rd_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module axi_lite_rd_xbar (
    input  wire logic                                aclk,
    input  wire logic                                aresetn,

    // ----------------------------------------------------------------------
    // Master side
    // ----------------------------------------------------------------------
    input  wire logic [`XBAR_N_MST*`XBAR_ADDR_W-1:0] araddr_i,
    input  wire logic [`XBAR_N_MST*3-1:0]            arprot_i,
    input  wire logic [`XBAR_N_MST-1:0]              arvalid_i,
    output logic      [`XBAR_N_MST-1:0]              arready_o,
    output logic      [`XBAR_N_MST*`XBAR_DATA_W-1:0] rdata_o,
    output logic      [`XBAR_N_MST*2-1:0]            rresp_o,
    output logic      [`XBAR_N_MST-1:0]              rvalid_o,
    input  wire logic [`XBAR_N_MST-1:0]              rready_i,

    // ----------------------------------------------------------------------
    // Slave side
    // ----------------------------------------------------------------------
    output logic      [`XBAR_N_SLV*`XBAR_ADDR_W-1:0] s_araddr_o,
    output logic      [`XBAR_N_SLV*3-1:0]            s_arprot_o,
    output logic      [`XBAR_N_SLV-1:0]              s_arvalid_o,
    input  wire logic [`XBAR_N_SLV-1:0]              s_arready_i,
    input  wire logic [`XBAR_N_SLV*`XBAR_DATA_W-1:0] s_rdata_i,
    input  wire logic [`XBAR_N_SLV*2-1:0]            s_rresp_i,
    input  wire logic [`XBAR_N_SLV-1:0]              s_rvalid_i,
    output logic      [`XBAR_N_SLV-1:0]              s_rready_o
);

    logic [`XBAR_N_MST-1:0][`XBAR_N_SLV-1:0] mst_req;
    logic [`XBAR_N_MST-1:0]                  mst_refuse;
    logic [`XBAR_N_SLV-1:0][`XBAR_N_MST-1:0] slv_req;
    logic [`XBAR_N_SLV-1:0][`XBAR_N_MST-1:0] slv_gnt;

    slv_rd_if u_bus ();

    for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_slv_port
        assign u_bus.arready[s] = s_arready_i[s];
        assign u_bus.rdata[s]   = s_rdata_i[s*`XBAR_DATA_W +: `XBAR_DATA_W];
        assign u_bus.rresp[s]   = s_rresp_i[s*2 +: 2];
        assign u_bus.rvalid[s]  = s_rvalid_i[s];

        assign s_araddr_o[s*`XBAR_ADDR_W +: `XBAR_ADDR_W] = u_bus.araddr[s];
        assign s_arprot_o[s*3 +: 3]                       = u_bus.arprot[s];
        assign s_arvalid_o[s]                             = u_bus.arvalid[s];
        assign s_rready_o[s]                              = u_bus.rready[s];
    end

    for (genvar m = 0; m < `XBAR_N_MST; m++) begin : g_dec
        rd_addr_decoder u_dec (
            .addr_i    (araddr_i[m*`XBAR_ADDR_W +: `XBAR_ADDR_W]),
            .prot_i    (arprot_i[m*3 +: 3]),
            .arvalid_i (arvalid_i[m]),
            .slv_req_o (mst_req[m]),
            .refuse_o  (mst_refuse[m])
        );
    end

    // Per-master rows into per-slave columns
    for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_req_t
        for (genvar m = 0; m < `XBAR_N_MST; m++) begin : g_mst
            assign slv_req[s][m] = mst_req[m][s];
        end
    end

    for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_arb
        rd_slave_arbiter #(.SLV_IDX(s)) u_arb (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .req_i     (slv_req[s]),
            .araddr_i  (araddr_i),
            .arprot_i  (arprot_i),
            .arvalid_i (arvalid_i),
            .rready_i  (rready_i),
            .gnt_o     (slv_gnt[s]),
            .bus       (u_bus.arb)
        );
    end

    for (genvar m = 0; m < `XBAR_N_MST; m++) begin : g_ret
        rd_master_return #(.MST_IDX(m)) u_ret (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .gnt_i     (slv_gnt),
            .refuse_i  (mst_refuse[m]),
            .arvalid_i (arvalid_i[m]),
            .rready_i  (rready_i[m]),
            .arready_o (arready_o[m]),
            .rdata_o   (rdata_o[m*`XBAR_DATA_W +: `XBAR_DATA_W]),
            .rresp_o   (rresp_o[m*2 +: 2]),
            .rvalid_o  (rvalid_o[m]),
            .bus       (u_bus.ret)
        );
    end

endmodule

`default_nettype wire

/* rd_master_return.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module rd_master_return #(
    parameter int MST_IDX = 0
) (
    input  wire logic                                     aclk,
    input  wire logic                                     aresetn,
    input  wire logic [`XBAR_N_SLV-1:0][`XBAR_N_MST-1:0]  gnt_i,
    input  wire logic                                     refuse_i,
    input  wire logic                                     arvalid_i,
    input  wire logic                                     rready_i,
    output logic                                          arready_o,
    output logic      [`XBAR_DATA_W-1:0]                  rdata_o,
    output axi_lite_pkg::resp_e                           rresp_o,
    output logic                                          rvalid_o,
    slv_rd_if.ret                                         bus
);

    // Pending DECERR for a refused read
    logic err_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            err_q <= 1'b0;
        end else if (!err_q && refuse_i && arvalid_i) begin
            err_q <= 1'b1;
        end else if (err_q && rready_i) begin
            err_q <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // ARREADY and R routing
    // ----------------------------------------------------------------------
    always_comb begin
        arready_o = 1'b0;
        rvalid_o  = err_q;
        rdata_o   = err_q ? `XBAR_ERR_DATA : '0;
        rresp_o   = err_q ? axi_lite_pkg::DECERR : axi_lite_pkg::OKAY;

        // Slave R stays blocked while the error beat is pending
        if (!err_q) begin
            if (refuse_i) begin
                // Refused read is taken at once
                arready_o = 1'b1;
            end else begin
                for (int s = 0; s < `XBAR_N_SLV; s++) begin
                    if (gnt_i[s][MST_IDX]) begin
                        arready_o = bus.arready[s];
                        rvalid_o  = bus.rvalid[s];
                        rdata_o   = bus.rdata[s];
                        rresp_o   = axi_lite_pkg::resp_e'(bus.rresp[s]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rd_slave_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module rd_slave_arbiter #(
    parameter int SLV_IDX = 0
) (
    input  wire logic                                      aclk,
    input  wire logic                                      aresetn,
    input  wire logic [`XBAR_N_MST-1:0]                    req_i,
    input  wire logic [`XBAR_N_MST-1:0][`XBAR_ADDR_W-1:0]  araddr_i,
    input  wire logic [`XBAR_N_MST-1:0][2:0]               arprot_i,
    input  wire logic [`XBAR_N_MST-1:0]                    arvalid_i,
    input  wire logic [`XBAR_N_MST-1:0]                    rready_i,
    output logic      [`XBAR_N_MST-1:0]                    gnt_o,
    slv_rd_if.arb                                          bus
);

    localparam int PTR_W = $clog2(`XBAR_N_MST);

    xbar_map_pkg::rd_lock_e  state_q;
    xbar_map_pkg::rd_lock_e  state_d;
    logic [PTR_W-1:0]        rr_ptr;
    logic [`XBAR_N_MST-1:0]  gnt_q;
    logic [`XBAR_N_MST-1:0]  nxt_gnt;
    logic [PTR_W-1:0]        nxt_idx;
    logic                    nxt_found;
    logic [`XBAR_ADDR_W-1:0] fwd_addr;
    logic [2:0]              fwd_prot;
    logic                    fwd_arvalid;
    logic                    fwd_rready;
    logic                    ar_hs;
    logic                    r_hs;
    logic                    lock;

    // ----------------------------------------------------------------------
    // Round-robin pick, starting after the last winner
    // ----------------------------------------------------------------------
    always_comb begin
        int idx;
        nxt_gnt   = '0;
        nxt_idx   = rr_ptr;
        nxt_found = 1'b0;
        for (int k = 1; k <= `XBAR_N_MST; k++) begin
            idx = (int'(rr_ptr) + k) % `XBAR_N_MST;
            if (!nxt_found && req_i[idx]) begin
                nxt_gnt[idx] = 1'b1;
                nxt_idx      = PTR_W'(idx);
                nxt_found    = 1'b1;
            end
        end
    end

    assign ar_hs = fwd_arvalid && bus.arready[SLV_IDX];
    assign r_hs  = (state_q == xbar_map_pkg::LOCK_R_PHASE) && bus.rvalid[SLV_IDX] && fwd_rready;
    assign lock  = (state_q == xbar_map_pkg::LOCK_R_PHASE) ||
                   (fwd_arvalid && !bus.arready[SLV_IDX]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            xbar_map_pkg::LOCK_IDLE:    if (ar_hs) state_d = xbar_map_pkg::LOCK_R_PHASE;
            xbar_map_pkg::LOCK_R_PHASE: if (r_hs)  state_d = xbar_map_pkg::LOCK_IDLE;
            default:                    state_d = xbar_map_pkg::LOCK_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= xbar_map_pkg::LOCK_IDLE;
            gnt_q   <= '0;
            rr_ptr  <= '0;
        end else begin
            state_q <= state_d;
            // Release the grant once the single R beat is taken
            if (r_hs) begin
                gnt_q <= '0;
            end else if (!lock && !ar_hs) begin
                gnt_q <= nxt_gnt;
                if (nxt_found) rr_ptr <= nxt_idx;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Forward AR and RREADY from the granted master
    // ----------------------------------------------------------------------
    always_comb begin
        fwd_addr    = '0;
        fwd_prot    = '0;
        fwd_arvalid = 1'b0;
        fwd_rready  = 1'b0;
        for (int m = 0; m < `XBAR_N_MST; m++) begin
            if (gnt_q[m]) begin
                fwd_addr    = araddr_i[m];
                fwd_prot    = arprot_i[m];
                // No second AR while the read is outstanding
                fwd_arvalid = arvalid_i[m] && req_i[m] &&
                              (state_q == xbar_map_pkg::LOCK_IDLE);
                fwd_rready  = rready_i[m];
            end
        end
    end

    assign bus.araddr[SLV_IDX]  = fwd_addr;
    assign bus.arprot[SLV_IDX]  = fwd_prot;
    assign bus.arvalid[SLV_IDX] = fwd_arvalid;
    assign bus.rready[SLV_IDX]  = fwd_rready;

    assign gnt_o = gnt_q;

endmodule

`default_nettype wire

/* rd_addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

module rd_addr_decoder (
    input  wire logic [`XBAR_ADDR_W-1:0] addr_i,
    input  wire logic [2:0]              prot_i,
    input  wire logic                    arvalid_i,
    output logic      [`XBAR_N_SLV-1:0]  slv_req_o,
    output logic                         refuse_o
);

    logic [`XBAR_N_SLV-1:0] hit;
    logic [`XBAR_N_SLV-1:0] allowed;
    logic                   nonsec;

    assign nonsec = prot_i[axi_lite_pkg::PROT_NONSEC_BIT];

    // ----------------------------------------------------------------------
    // Region lookup
    // ----------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < `XBAR_N_SLV; s++) begin
            hit[s] = (addr_i & xbar_map_pkg::REGION_MAP[s].mask) ==
                     (xbar_map_pkg::REGION_MAP[s].base & xbar_map_pkg::REGION_MAP[s].mask);
            // Secure-only regions reject non-secure masters
            allowed[s] = hit[s] && !(xbar_map_pkg::REGION_MAP[s].secure_only && nonsec);
        end
    end

    // Request only while the address is valid
    assign slv_req_o = arvalid_i ? allowed : '0;

    // No match, or a match that security forbids
    assign refuse_o = arvalid_i && !(|allowed);

endmodule

`default_nettype wire

/* slv_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_defs.svh"

interface slv_rd_if;

    // AR channel, one entry per slave port
    logic [`XBAR_ADDR_W-1:0] araddr  [`XBAR_N_SLV];
    logic [2:0]              arprot  [`XBAR_N_SLV];
    logic                    arvalid [`XBAR_N_SLV];
    logic                    arready [`XBAR_N_SLV];

    // R channel
    logic [`XBAR_DATA_W-1:0] rdata   [`XBAR_N_SLV];
    logic [1:0]              rresp   [`XBAR_N_SLV];
    logic                    rvalid  [`XBAR_N_SLV];
    logic                    rready  [`XBAR_N_SLV];

    // Slave-side arbiters drive the forward AR and RREADY
    modport arb (
        output araddr, arprot, arvalid, rready,
        input  arready, rvalid
    );

    // Master-side return muxes only observe
    modport ret (
        input arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

/* xbar_map_pkg.sv */
`default_nettype none

`include "axi_xbar_defs.svh"

package xbar_map_pkg;

    // Per-slave read lock, held from AR acceptance to the R handshake
    typedef enum logic {
        LOCK_IDLE,
        LOCK_R_PHASE
    } rd_lock_e;

    typedef struct packed {
        logic [`XBAR_ADDR_W-1:0] base;
        logic [`XBAR_ADDR_W-1:0] mask;
        logic                    secure_only;
    } region_t;

    // Indexed by slave
    localparam region_t REGION_MAP [`XBAR_N_SLV] = '{
        '{base: `XBAR_REG0_BASE, mask: `XBAR_REG0_MASK, secure_only: 1'b1},
        '{base: `XBAR_REG1_BASE, mask: `XBAR_REG1_MASK, secure_only: 1'b0}
    };

endpackage

`default_nettype wire

/* axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    // AXI response encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // ARPROT[1] high marks a non-secure access
    localparam int PROT_NONSEC_BIT = 1;

endpackage

`default_nettype wire

/* axi_xbar_defs.svh */
`ifndef AXI_XBAR_DEFS_SVH
`define AXI_XBAR_DEFS_SVH

// ----------------------------------------------------------------------
// Bus widths and matrix size
// ----------------------------------------------------------------------
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_N_MST 2
`define XBAR_N_SLV 2

// ----------------------------------------------------------------------
// Region map, upper 16 address bits compared
// ----------------------------------------------------------------------
`define XBAR_REG0_BASE 32'h0000_0000
`define XBAR_REG0_MASK 32'hFFFF_0000
`define XBAR_REG1_BASE 32'h1000_0000
`define XBAR_REG1_MASK 32'hFFFF_0000

// Read data returned with DECERR
`define XBAR_ERR_DATA 32'hDEAD_BEEF

`endif
